// File: hdl/lsuPkg.sv
package lsuPkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // Data path and register width
  parameter int XLen = 32;
  // Physical address width, no translation in front of the LSU
  parameter int PAddrW = 32;

  ////////////////////////////////////////
  // Codes
  ////////////////////////////////////////

  // Access kind presented by the pipeline
  typedef enum logic [2:0] {
    opNone,
    opLoad,
    opStore,
    opLoadRes,
    opStoreCond
  } lsuOpE;

  // Size code, same encoding as funct3[1:0]
  typedef enum logic [1:0] {
    szByte,
    szHalf,
    szWord,
    szDouble
  } lsuSizeE;

  // Fault reported with the done pulse
  typedef enum logic [2:0] {
    fNone,
    fLoadMisaligned,
    fStoreMisaligned,
    fLoadAccess,
    fStoreAccess
  } lsuFaultE;

  ////////////////////////////////////////
  // Structs
  ////////////////////////////////////////

  // Request from the memory stage
  typedef struct packed {
    lsuOpE              op;
    lsuSizeE            size;
    logic               unsignedLoad;
    logic [PAddrW-1:0]  addr;
    logic [XLen-1:0]    writeData;
  } lsuReqT;

  // Response back to the pipeline, fields valid with done only
  typedef struct packed {
    logic               done;
    logic [XLen-1:0]    readData;
    lsuFaultE           fault;
    logic               scFail;
  } lsuRespT;

  // Single-beat bus request
  typedef struct packed {
    logic               read;
    logic               write;
    logic [PAddrW-1:0]  wordAddr;
    logic [XLen-1:0]    writeData;
    logic [XLen/8-1:0]  byteEn;
  } busReqT;

  // Region table entry, limit is inclusive
  typedef struct packed {
    logic               valid;
    logic               writable;
    logic [PAddrW-1:0]  base;
    logic [PAddrW-1:0]  limit;
  } regionT;

  // Stores and store-conditionals both write memory
  function automatic logic isWriteOp(lsuOpE op);
    return (op == opStore) || (op == opStoreCond);
  endfunction

endpackage

// File: hdl/lsuRegionCfg.sv
`timescale 1ns/1ns

module lsuRegionCfg #(
  parameter int NumRegions = 4
) (
  input  logic                              clk,
  input  logic                              rstN,
  // Configuration write port
  input  logic                              cfgWe,
  input  logic [$clog2(NumRegions)-1:0]     cfgIdx,
  input  lsuPkg::regionT                    cfgEntry,
  // Access being checked
  input  logic [lsuPkg::PAddrW-1:0]         addr,
  input  logic                              isStore,
  output logic                              accessOk
);

  import lsuPkg::*;

  localparam int IdxW = $clog2(NumRegions);

  ////////////////////////////////////////
  // Region table
  ////////////////////////////////////////

  regionT                regions [NumRegions];
  logic [NumRegions-1:0] hit;

  // One entry written per strobe
  // Only the valid bits return to zero on reset
  always_ff @(posedge clk) begin
    for (int i = 0; i < NumRegions; i++) begin
      if (!rstN) begin
        regions[i].valid <= 1'b0;
      end else if (cfgWe && (cfgIdx == IdxW'(i))) begin
        regions[i] <= cfgEntry;
      end
    end
  end

  ////////////////////////////////////////
  // Permission check
  ////////////////////////////////////////

  // Per-entry match
  // Address inside [base, limit], and write permission for stores
  always_comb begin
    for (int i = 0; i < NumRegions; i++) begin
      hit[i] = regions[i].valid
               && (addr >= regions[i].base)
               && (addr <= regions[i].limit)
               && (!isStore || regions[i].writable);
    end
  end

  // Any matching entry grants the access
  // Overlapping entries simply OR together
  assign accessOk = |hit;

endmodule

// File: hdl/lsuAlign.sv
`timescale 1ns/1ns

module lsuAlign (
  input  lsuPkg::lsuReqT                req,
  input  logic [lsuPkg::XLen-1:0]       busRdata,
  output logic                          misaligned,
  output logic [lsuPkg::XLen/8-1:0]     byteEn,
  output logic [lsuPkg::XLen-1:0]       wdataPlaced,
  output logic [lsuPkg::XLen-1:0]       loadData
);

  import lsuPkg::*;

  // Byte lanes per word
  localparam int BeW  = XLen / 8;
  localparam int OffW = $clog2(BeW);

  logic [OffW-1:0] offset;
  logic [XLen-1:0] shifted;
  logic            byteSign;
  logic            halfSign;

  // Byte offset inside the word
  assign offset = req.addr[OffW-1:0];

  ////////////////////////////////////////
  // Alignment
  ////////////////////////////////////////

  // Natural alignment per size
  // Doubleword never fits a 32-bit bus
  always_comb begin
    case (req.size)
      szByte:  misaligned = 1'b0;
      szHalf:  misaligned = offset[0];
      szWord:  misaligned = |offset;
      default: misaligned = 1'b1;
    endcase
  end

  ////////////////////////////////////////
  // Store side
  ////////////////////////////////////////

  // Byte enables follow size and offset
  always_comb begin
    case (req.size)
      szByte:  byteEn = BeW'(1) << offset;
      szHalf:  byteEn = BeW'(3) << offset;
      szWord:  byteEn = '1;
      default: byteEn = '0;
    endcase
  end

  // Replicate the low bytes into every lane
  // The enables then pick the lanes that land in memory
  always_comb begin
    case (req.size)
      szByte:  wdataPlaced = {BeW{req.writeData[7:0]}};
      szHalf:  wdataPlaced = {(BeW/2){req.writeData[15:0]}};
      default: wdataPlaced = req.writeData;
    endcase
  end

  ////////////////////////////////////////
  // Load side
  ////////////////////////////////////////

  // Move the addressed lanes down to bit 0
  assign shifted = busRdata >> {offset, 3'b000};

  // Sign fill only for signed loads
  assign byteSign = !req.unsignedLoad && shifted[7];
  assign halfSign = !req.unsignedLoad && shifted[15];

  // Extend sub-word data to the full register
  always_comb begin
    case (req.size)
      szByte:  loadData = {{(XLen-8){byteSign}}, shifted[7:0]};
      szHalf:  loadData = {{(XLen-16){halfSign}}, shifted[15:0]};
      szWord:  loadData = busRdata;
      // Doubleword never reaches the bus
      default: loadData = '0;
    endcase
  end

endmodule

// File: hdl/lsuReservation.sv
`timescale 1ns/1ns

module lsuReservation (
  input  logic            clk,
  input  logic            rstN,
  input  lsuPkg::lsuReqT  req,
  // High in the done cycle of an access that moves the reservation
  input  logic            commit,
  output logic            scSquash
);

  import lsuPkg::*;

  ////////////////////////////////////////
  // Reservation register
  ////////////////////////////////////////

  logic                resValid;
  logic [PAddrW-1:2]   resAddr;
  logic [PAddrW-1:2]   reqWord;
  logic                resMatch;

  // Reservation granule is one word
  assign reqWord  = req.addr[PAddrW-1:2];
  assign resMatch = resValid && (resAddr == reqWord);

  // LR sets, any SC clears
  always_ff @(posedge clk) begin
    if (!rstN) begin
      resValid <= 1'b0;
    end else if (commit) begin
      if (req.op == opLoadRes) begin
        resValid <= 1'b1;
      end else if (req.op == opStoreCond) begin
        resValid <= 1'b0;
      end
    end
  end

  // Word address captured by an acknowledged LR
  always_ff @(posedge clk) begin
    if (commit && (req.op == opLoadRes)) begin
      resAddr <= reqWord;
    end
  end

  // SC without a live reservation on its word never reaches the bus
  assign scSquash = (req.op == opStoreCond) && !resMatch;

endmodule

// File: hdl/lsuBusCtrl.sv
`timescale 1ns/1ns

module lsuBusCtrl (
  input  logic                          clk,
  input  logic                          rstN,
  input  lsuPkg::lsuReqT                req,
  input  logic                          reject,
  input  lsuPkg::lsuFaultE              fault,
  input  logic                          scSquash,
  input  logic [lsuPkg::XLen-1:0]       wdataPlaced,
  input  logic [lsuPkg::XLen/8-1:0]     byteEn,
  input  logic [lsuPkg::XLen-1:0]       loadData,
  input  logic                          busAck,
  output lsuPkg::busReqT                busReq,
  output logic                          stall,
  output lsuPkg::lsuRespT               resp,
  output logic                          commit
);

  import lsuPkg::*;

  typedef enum logic [1:0] {stIdle, stBusy, stDone, stRejectDone} stateE;

  stateE           state;
  stateE           stateNext;
  lsuOpE           opQ;
  lsuFaultE        faultQ;
  logic            scFailQ;
  logic [XLen-1:0] loadDataQ;
  logic            reqValid;
  logic            accept;

  assign reqValid = req.op != opNone;
  // Request sampled only from idle
  assign accept   = (state == stIdle) && reqValid;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_comb begin
    stateNext = state;
    case (state)
      stIdle:       if (reqValid) stateNext = reject ? stRejectDone : stBusy;
      stBusy:       if (busAck) stateNext = stDone;
      default:      stateNext = stIdle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstN) state <= stIdle;
    else       state <= stateNext;
  end

  ////////////////////////////////////////
  // Bus request and captured access
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    // Payload captured at acceptance
    if (accept) begin
      busReq.wordAddr  <= {req.addr[PAddrW-1:2], 2'b00};
      busReq.writeData <= wdataPlaced;
      busReq.byteEn    <= byteEn;
      opQ              <= req.op;
      faultQ           <= fault;
      // A faulting SC reports the fault, not a failure
      scFailQ          <= scSquash && (fault == fNone);
    end
    // Load data held from the ack edge
    if ((state == stBusy) && busAck) loadDataQ <= loadData;
    // Strobes up from cycle 1 until the ack cycle
    if (!rstN) begin
      busReq.read  <= 1'b0;
      busReq.write <= 1'b0;
    end else if (accept && !reject) begin
      busReq.read  <= !isWriteOp(req.op);
      busReq.write <= isWriteOp(req.op);
    end else if ((state == stBusy) && busAck) begin
      busReq.read  <= 1'b0;
      busReq.write <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Pipeline side
  ////////////////////////////////////////

  // Low again in the done cycle
  assign stall  = accept || (state == stBusy);
  // Every SC clears the reservation whether it fails or faults
  assign commit = (state == stDone) || ((state == stRejectDone) && (opQ == opStoreCond));

  always_comb begin
    resp = '0;
    case (state)
      stDone: begin
        resp.done     = 1'b1;
        // Stores and successful SC return zero
        resp.readData = isWriteOp(opQ) ? '0 : loadDataQ;
      end
      stRejectDone: begin
        resp.done     = 1'b1;
        resp.fault    = faultQ;
        resp.scFail   = scFailQ;
        resp.readData = XLen'(scFailQ);
      end
      default: resp = '0;
    endcase
  end

endmodule

// File: hdl/lsu.sv
`timescale 1ns/1ns

module lsu #(
  parameter int NumRegions = 4
) (
  input  logic                              clk,
  input  logic                              rstN,
  // Pipeline side
  input  lsuPkg::lsuReqT                    req,
  output lsuPkg::lsuRespT                   resp,
  output logic                              stall,
  // Region table writes
  input  logic                              cfgWe,
  input  logic [$clog2(NumRegions)-1:0]     cfgIdx,
  input  lsuPkg::regionT                    cfgEntry,
  // External bus
  output lsuPkg::busReqT                    busReq,
  input  logic                              busAck,
  input  logic [lsuPkg::XLen-1:0]           busRdata
);

  import lsuPkg::*;

  logic                accessOk;
  logic                misaligned;
  logic [XLen/8-1:0]   byteEn;
  logic [XLen-1:0]     wdataPlaced;
  logic [XLen-1:0]     loadData;
  logic                scSquash;
  logic                commit;
  logic                isStore;
  logic                reject;
  lsuFaultE            fault;

  // SC checks store permission too
  assign isStore = isWriteOp(req.op);

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  lsuRegionCfg #(
    .NumRegions(NumRegions)
  ) regionCfg_i (
    .clk      (clk),
    .rstN     (rstN),
    .cfgWe    (cfgWe),
    .cfgIdx   (cfgIdx),
    .cfgEntry (cfgEntry),
    .addr     (req.addr),
    .isStore  (isStore),
    .accessOk (accessOk)
  );

  lsuAlign align_i (
    .req         (req),
    .busRdata    (busRdata),
    .misaligned  (misaligned),
    .byteEn      (byteEn),
    .wdataPlaced (wdataPlaced),
    .loadData    (loadData)
  );

  lsuReservation reservation_i (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .commit   (commit),
    .scSquash (scSquash)
  );

  // Misalignment wins over a region fault
  // Load or store flavor follows the op
  always_comb begin
    if (misaligned)     fault = isStore ? fStoreMisaligned : fLoadMisaligned;
    else if (!accessOk) fault = isStore ? fStoreAccess : fLoadAccess;
    else                fault = fNone;
  end

  // No bus access for faults or a lost SC
  assign reject = (fault != fNone) || scSquash;

  ////////////////////////////////////////
  // Access sequencing
  ////////////////////////////////////////

  lsuBusCtrl busCtrl_i (
    .clk         (clk),
    .rstN        (rstN),
    .req         (req),
    .reject      (reject),
    .fault       (fault),
    .scSquash    (scSquash),
    .wdataPlaced (wdataPlaced),
    .byteEn      (byteEn),
    .loadData    (loadData),
    .busAck      (busAck),
    .busReq      (busReq),
    .stall       (stall),
    .resp        (resp),
    .commit      (commit)
  );

endmodule

// File: tb/lsuClkGen.sv
`timescale 1ns/1ns

module lsuClkGen #(
  parameter int Period      = 100,
  parameter int ResetCycles = 3
) (
  output logic clk,
  output logic rstN
);

  // Free-running clock, first rising edge at half a period
  initial begin
    clk = 1'b0;
    forever #(Period / 2) clk = ~clk;
  end

  // Reset seen by ResetCycles rising edges, released on a falling edge
  initial begin
    rstN = 1'b0;
    repeat (ResetCycles) @(negedge clk);
    rstN = 1'b1;
  end

endmodule

// File: tb/lsu_assertions.sv
`timescale 1ns/1ns

module lsu_assertions (
  input  logic             clk,
  input  logic             rstN,
  input  lsuPkg::busReqT   busReq,
  input  logic             busAck,
  input  logic             stall,
  input  lsuPkg::lsuRespT  resp
);

  ////////////////////////////////////////
  // Bus protocol
  ////////////////////////////////////////

  // One direction per access
  strobesExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(busReq.read && busReq.write))
    else $error("bus read and write strobes high together");

  // Whole request frozen while waiting for the acknowledge
  reqHeldUntilAck: assert property (@(posedge clk) disable iff (!rstN)
    ((busReq.read || busReq.write) && !busAck) |=> $stable(busReq))
    else $error("bus request changed before the acknowledge");

  ////////////////////////////////////////
  // Pipeline side
  ////////////////////////////////////////

  // Done is a single-cycle pulse
  donePulse: assert property (@(posedge clk) disable iff (!rstN)
    resp.done |=> !resp.done)
    else $error("done high in two consecutive cycles");

  // Pipeline released in the done cycle
  stallLowAtDone: assert property (@(posedge clk) disable iff (!rstN)
    resp.done |-> !stall)
    else $error("stall high in the done cycle");

endmodule

bind lsuBusCtrl lsu_assertions assertions_i (
  .clk    (clk),
  .rstN   (rstN),
  .busReq (busReq),
  .busAck (busAck),
  .stall  (stall),
  .resp   (resp)
);

// File: tb/lsuTb.sv
`timescale 1ns/1ns

module lsuTb;

  import lsuPkg::*;

  localparam int NumRegions    = 4;
  localparam int MemWords      = 64;
  localparam int TimeoutCycles = 20;
  // Table entries run before any region is configured
  localparam int NumPreCfg     = 2;

  logic                          clk;
  logic                          rstN;
  lsuReqT                        req      = '0;
  lsuRespT                       resp;
  logic                          stall;
  logic                          cfgWe    = 1'b0;
  logic [$clog2(NumRegions)-1:0] cfgIdx   = '0;
  regionT                        cfgEntry = '0;
  busReqT                        busReq;
  logic                          busAck   = 1'b0;
  logic [XLen-1:0]               busRdata = '0;

  int         errors      = 0;
  int         busErrors   = 0;
  int         testsRun    = 0;
  int         testsFailed = 0;
  int         busAccesses = 0;
  int         waitLeft    = -1;
  logic [3:0] lastBe      = '0;
  logic [XLen-1:0] lastAddr = '0;
  logic       timedOut    = 1'b0;
  busReqT     heldReq;
  logic [XLen-1:0] mem [MemWords];

  // Stimulus table with one entry per index
  string           names[$];
  lsuReqT          reqs[$];
  logic [XLen-1:0] expData[$];
  lsuFaultE        expFault[$];
  logic            expSc[$];
  logic [3:0]      expBe[$];

  lsuClkGen #(.Period(100), .ResetCycles(3)) clkGen_i (.clk(clk), .rstN(rstN));

  lsu #(.NumRegions(NumRegions)) dut_i (
    .clk      (clk),
    .rstN     (rstN),
    .req      (req),
    .resp     (resp),
    .stall    (stall),
    .cfgWe    (cfgWe),
    .cfgIdx   (cfgIdx),
    .cfgEntry (cfgEntry),
    .busReq   (busReq),
    .busAck   (busAck),
    .busRdata (busRdata)
  );

  ////////////////////////////////////////
  // Bus memory model
  ////////////////////////////////////////

  // Every byte holds the low bits of its own byte address
  function automatic logic [XLen-1:0] fillWord(input int w);
    logic [7:0] a;
    a = 8'(w * 4);
    return {a + 8'd3, a + 8'd2, a + 8'd1, a};
  endfunction

  // Ack after 0 to 3 random wait cycles on the falling edge
  always @(negedge clk) begin
    if (!rstN) begin
      for (int w = 0; w < MemWords; w++) begin
        mem[w] = fillWord(w);
      end
      busAck   = 1'b0;
      waitLeft = -1;
    end else if (busAck) begin
      busAck = 1'b0;
    end else if (busReq.read || busReq.write) begin
      if (waitLeft < 0) begin
        waitLeft = int'($urandom_range(3, 0));
        heldReq  = busReq;
      end
      assert ((busReq == heldReq) && !(busReq.read && busReq.write)) else begin
        $display("Bus request changed or both strobes high while waiting");
        busErrors++;
      end
      if (waitLeft == 0) begin
        busAck   = 1'b1;
        busRdata = mem[busReq.wordAddr[7:2]];
        lastAddr = busReq.wordAddr;
        busAccesses++;
        // Only enabled lanes land in memory
        if (busReq.write) begin
          lastBe = busReq.byteEn;
          for (int b = 0; b < 4; b++) begin
            if (busReq.byteEn[b]) begin
              mem[busReq.wordAddr[7:2]][8*b +: 8] = busReq.writeData[8*b +: 8];
            end
          end
        end
        waitLeft = -1;
      end else begin
        waitLeft--;
      end
    end
  end

  ////////////////////////////////////////
  // Table
  ////////////////////////////////////////

  task automatic addTest(input string name, input lsuOpE op, input lsuSizeE size,
                         input logic uns, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [31:0] data, input lsuFaultE fault, input logic sc,
                         input logic [3:0] be);
    lsuReqT r;
    r.op           = op;
    r.size         = size;
    r.unsignedLoad = uns;
    r.addr         = addr;
    r.writeData    = wdata;
    names.push_back(name);
    reqs.push_back(r);
    expData.push_back(data);
    expFault.push_back(fault);
    expSc.push_back(sc);
    expBe.push_back(be);
  endtask

  // Expected load values follow the fill pattern and earlier stores
  task automatic buildTable();
    addTest("noRegionLoad", opLoad, szWord, 1'b0, 32'h10, 0, 0, fLoadAccess, 1'b0, 4'h0);
    addTest("noRegionStore", opStore, szWord, 1'b0, 32'h10, 0, 0, fStoreAccess, 1'b0, 4'h0);
    addTest("storeWord", opStore, szWord, 1'b0, 32'h20, 32'h8badf00d, 0, fNone, 1'b0, 4'hf);
    addTest("loadWord", opLoad, szWord, 1'b0, 32'h20, 0, 32'h8badf00d, fNone, 1'b0, 4'h0);
    addTest("storeHalfHi", opStore, szHalf, 1'b0, 32'h26, 32'h12348765, 0, fNone, 1'b0, 4'hc);
    addTest("loadHalfSigned", opLoad, szHalf, 1'b0, 32'h26, 0, 32'hffff8765, fNone, 1'b0, 4'h0);
    addTest("loadHalfUns", opLoad, szHalf, 1'b1, 32'h26, 0, 32'h00008765, fNone, 1'b0, 4'h0);
    addTest("storeByte", opStore, szByte, 1'b0, 32'h29, 32'h000000f0, 0, fNone, 1'b0, 4'h2);
    addTest("loadByteSigned", opLoad, szByte, 1'b0, 32'h29, 0, 32'hfffffff0, fNone, 1'b0, 4'h0);
    addTest("loadByteUns", opLoad, szByte, 1'b1, 32'h29, 0, 32'h000000f0, fNone, 1'b0, 4'h0);
    addTest("loadWordMixed", opLoad, szWord, 1'b0, 32'h28, 0, 32'h2b2af028, fNone, 1'b0, 4'h0);
    addTest("loadByteKept", opLoad, szByte, 1'b0, 32'h2a, 0, 32'h0000002a, fNone, 1'b0, 4'h0);
    addTest("misHalfLoad", opLoad, szHalf, 1'b0, 32'h21, 0, 0, fLoadMisaligned, 1'b0, 4'h0);
    addTest("misWordStore", opStore, szWord, 1'b0, 32'h22, 0, 0, fStoreMisaligned, 1'b0, 4'h0);
    addTest("doubleLoad", opLoad, szDouble, 1'b0, 32'h20, 0, 0, fLoadMisaligned, 1'b0, 4'h0);
    addTest("doubleStore", opStore, szDouble, 1'b0, 32'h30, 0, 0, fStoreMisaligned, 1'b0, 4'h0);
    addTest("misOutside", opLoad, szWord, 1'b0, 32'h201, 0, 0, fLoadMisaligned, 1'b0, 4'h0);
    addTest("roLoadWord", opLoad, szWord, 1'b0, 32'hc4, 0, 32'hc7c6c5c4, fNone, 1'b0, 4'h0);
    addTest("roLoadByte", opLoad, szByte, 1'b0, 32'hc5, 0, 32'hffffffc5, fNone, 1'b0, 4'h0);
    addTest("roStore", opStore, szWord, 1'b0, 32'hc8, 32'h5a5a5a5a, 0, fStoreAccess, 1'b0, 4'h0);
    addTest("outsideLoad", opLoad, szWord, 1'b0, 32'h100, 0, 0, fLoadAccess, 1'b0, 4'h0);
    addTest("outsideStore", opStore, szByte, 1'b0, 32'h400, 0, 0, fStoreAccess, 1'b0, 4'h0);
    addTest("lrWord", opLoadRes, szWord, 1'b0, 32'h40, 0, 32'h43424140, fNone, 1'b0, 4'h0);
    addTest("scWord", opStoreCond, szWord, 1'b0, 32'h40, 32'hcafebabe, 0, fNone, 1'b0, 4'hf);
    addTest("scRepeat", opStoreCond, szWord, 1'b0, 32'h40, 32'h11111111, 1, fNone, 1'b1, 4'h0);
    addTest("loadAfterSc", opLoad, szWord, 1'b0, 32'h40, 0, 32'hcafebabe, fNone, 1'b0, 4'h0);
    addTest("lrAgain", opLoadRes, szWord, 1'b0, 32'h44, 0, 32'h47464544, fNone, 1'b0, 4'h0);
    addTest("scOtherWord", opStoreCond, szWord, 1'b0, 32'h48, 32'h22222222, 1, fNone, 1'b1, 4'h0);
    addTest("scAfterLoss", opStoreCond, szWord, 1'b0, 32'h44, 32'h33333333, 1, fNone, 1'b1, 4'h0);
    addTest("loadOther", opLoad, szWord, 1'b0, 32'h48, 0, 32'h4b4a4948, fNone, 1'b0, 4'h0);
    // A faulting SC still drops the reservation
    addTest("lrThird", opLoadRes, szWord, 1'b0, 32'h4c, 0, 32'h4f4e4d4c, fNone, 1'b0, 4'h0);
    addTest("scMisalign", opStoreCond, szWord, 1'b0, 32'h4e, 0, 0, fStoreMisaligned, 1'b0, 4'h0);
    addTest("scAfterFault", opStoreCond, szWord, 1'b0, 32'h4c, 32'h55555555, 1, fNone, 1'b1, 4'h0);
  endtask

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // One entry per call takes effect at the next rising edge
  task automatic writeRegion(input logic [1:0] idx, input logic writable,
                             input logic [31:0] base, input logic [31:0] limit);
    cfgWe             = 1'b1;
    cfgIdx            = idx;
    cfgEntry.valid    = 1'b1;
    cfgEntry.writable = writable;
    cfgEntry.base     = base;
    cfgEntry.limit    = limit;
    @(negedge clk);
    cfgWe = 1'b0;
  endtask

  task automatic configRegions();
    // Writable RAM below the read-only window
    writeRegion(2'd0, 1'b1, 32'h0000_0000, 32'h0000_00bf);
    // Read-only window at the top of the model
    writeRegion(2'd1, 1'b0, 32'h0000_00c0, 32'h0000_00ff);
  endtask

  task automatic reportTest(input string name, input int errBefore);
    testsRun++;
    if (errors + busErrors == errBefore) begin
      $display("test %s passed", name);
    end else begin
      testsFailed++;
      $display("test %s failed", name);
    end
  endtask

  // Every output stays quiet without a request
  task automatic checkIdle();
    int errBefore;
    errBefore = errors + busErrors;
    repeat (4) begin
      @(negedge clk);
      assert (!stall && !resp.done && !busReq.read && !busReq.write) else begin
        $display("[FAIL] idleAfterReset stall/done/read/write expected 0000 actual %b%b%b%b",
                 stall, resp.done, busReq.read, busReq.write);
        errors++;
      end
    end
    reportTest("idleAfterReset", errBefore);
  endtask

  task automatic runTest(input int i);
    int              cycles;
    int              errBefore;
    int              busBefore;
    int              busExpected;
    logic            sawDone;
    logic [XLen-1:0] expAddr;
    errBefore   = errors + busErrors;
    busBefore   = busAccesses;
    cycles      = 0;
    sawDone     = 1'b0;
    // Faults and lost SCs make no bus cycle
    busExpected = ((expFault[i] == fNone) && !expSc[i]) ? 1 : 0;
    req         = reqs[i];
    // Bus sees the word address with the low two bits cleared
    expAddr     = {req.addr[PAddrW-1:2], 2'b00};
    // Request held and stall checked every cycle until done
    while (!sawDone && (cycles < TimeoutCycles)) begin
      @(negedge clk);
      cycles++;
      assert ((busExpected == 1) || (!busReq.read && !busReq.write)) else begin
        $display("%s: bus strobe raised for a rejected access", names[i]);
        errors++;
      end
      if (resp.done) begin
        sawDone = 1'b1;
      end else begin
        assert (stall) else begin
          $display("%s: stall dropped before done", names[i]);
          errors++;
        end
      end
    end
    if (!sawDone) begin
      $display("%s: no done within %0d cycles", names[i], TimeoutCycles);
      errors++;
      timedOut = 1'b1;
    end else begin
      // Rejected accesses finish one cycle after acceptance
      assert ((busExpected == 1) || (cycles == 1)) else begin
        $display("%s: rejected access took %0d cycles to finish", names[i], cycles);
        errors++;
      end
      assert (!stall) else begin
        $display("%s: stall still high in the done cycle", names[i]);
        errors++;
      end
      assert (resp.readData == expData[i]) else begin
        $display("[FAIL] %s readData expected %h actual %h",
                 names[i], expData[i], resp.readData);
        errors++;
      end
      assert (resp.fault == expFault[i]) else begin
        $display("[FAIL] %s fault expected %0d actual %0d", names[i], expFault[i], resp.fault);
        errors++;
      end
      assert (resp.scFail == expSc[i]) else begin
        $display("[FAIL] %s scFail expected %b actual %b", names[i], expSc[i], resp.scFail);
        errors++;
      end
      // Request still held through the done cycle for the reservation update
      @(negedge clk);
      assert (!resp.done) else begin
        $display("%s: done pulse longer than one cycle", names[i]);
        errors++;
      end
      assert (busAccesses - busBefore == busExpected) else begin
        $display("[FAIL] %s bus accesses expected %0d actual %0d",
                 names[i], busExpected, busAccesses - busBefore);
        errors++;
      end
      if (busExpected == 1) begin
        assert (lastAddr == expAddr) else begin
          $display("[FAIL] %s wordAddr expected %h actual %h", names[i], expAddr, lastAddr);
          errors++;
        end
      end
      if ((busExpected == 1) && (expBe[i] != 4'h0)) begin
        assert (lastBe == expBe[i]) else begin
          $display("[FAIL] %s byteEn expected %b actual %b", names[i], expBe[i], lastBe);
          errors++;
        end
      end
    end
    req = '0;
    reportTest(names[i], errBefore);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int cycles;
    void'($urandom(32'h6c67));
    buildTable();
    cycles = 0;
    while ((rstN !== 1'b1) && (cycles < TimeoutCycles)) begin
      @(negedge clk);
      cycles++;
    end
    if (rstN !== 1'b1) begin
      $display("Reset was never released");
      errors++;
      timedOut = 1'b1;
    end else begin
      checkIdle();
      for (int i = 0; i < names.size(); i++) begin
        if (i == NumPreCfg) begin
          configRegions();
        end
        runTest(i);
        if (timedOut) begin
          break;
        end
      end
    end
    $display("Summary: %0d tests, %0d failed, %0d check errors",
             testsRun, testsFailed, errors + busErrors);
    if ((errors + busErrors == 0) && !timedOut) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: lsu.f
hdl/lsuPkg.sv
hdl/lsuRegionCfg.sv
hdl/lsuAlign.sv
hdl/lsuReservation.sv
hdl/lsuBusCtrl.sv
hdl/lsu.sv
tb/lsuClkGen.sv
tb/lsu_assertions.sv
tb/lsuTb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
RUNFLAGS  := +verilator+error+limit+100
TOP       := lsuTb
FILELIST  := lsu.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := Errors found
PASS_MSG  := No errors
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) $(RUNFLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
